// File: logic/priv_csr_pkg.sv
`default_nettype none
// Shared types and constants for the RV32 machine-mode CSR block
// misa is fixed to RV32I; no supervisor, user, FP or vector state exists
package priv_csr_pkg;

  parameter int XLEN = 32;

  // CSR access operation
  typedef enum logic [1:0] {
    CSR_READ = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_t;

  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    S_MODE = 2'd1,
    M_MODE = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } mtvec_mode_t;

  // Machine information, read-only
  parameter logic [11:0] MVENDORID_ADDR     = 12'hF11;
  parameter logic [11:0] MARCHID_ADDR       = 12'hF12;
  parameter logic [11:0] MIMPID_ADDR        = 12'hF13;
  parameter logic [11:0] MHARTID_ADDR       = 12'hF14;
  parameter logic [11:0] MCONFIGPTR_ADDR    = 12'hF15;

  // Trap setup
  parameter logic [11:0] MSTATUS_ADDR       = 12'h300;
  parameter logic [11:0] MISA_ADDR          = 12'h301;
  parameter logic [11:0] MIE_ADDR           = 12'h304;
  parameter logic [11:0] MTVEC_ADDR         = 12'h305;
  parameter logic [11:0] MCOUNTEREN_ADDR    = 12'h306;
  parameter logic [11:0] MSTATUSH_ADDR      = 12'h310;

  // Trap handling
  parameter logic [11:0] MSCRATCH_ADDR      = 12'h340;
  parameter logic [11:0] MEPC_ADDR          = 12'h341;
  parameter logic [11:0] MCAUSE_ADDR        = 12'h342;
  parameter logic [11:0] MTVAL_ADDR         = 12'h343;
  parameter logic [11:0] MIP_ADDR           = 12'h344;

  // Counters
  parameter logic [11:0] MCOUNTINHIBIT_ADDR = 12'h320;
  parameter logic [11:0] MCYCLE_ADDR        = 12'hB00;
  parameter logic [11:0] MINSTRET_ADDR      = 12'hB02;
  parameter logic [11:0] MCYCLEH_ADDR       = 12'hB80;
  parameter logic [11:0] MINSTRETH_ADDR     = 12'hB82;

  // mstatus field positions
  parameter int MSTATUS_MIE_BIT  = 3;
  parameter int MSTATUS_MPIE_BIT = 7;
  parameter int MSTATUS_MPP_LSB  = 11;  // Two bits wide
  parameter int MSTATUS_MPRV_BIT = 17;
  parameter int MSTATUS_TW_BIT   = 21;

  // Interrupt bits, same place in mie and mip
  parameter int IRQ_SW_BIT    = 3;
  parameter int IRQ_TIMER_BIT = 7;
  parameter int IRQ_EXT_BIT   = 11;
  parameter logic [XLEN-1:0] MIE_MASK = 32'h0000_0888;

  // Counter enable and inhibit bits
  parameter int CNT_CY_BIT = 0;
  parameter int CNT_IR_BIT = 2;

  // MXL=1 (RV32), extension I only
  parameter logic [XLEN-1:0] MISA_VALUE       = 32'h4000_0100;
  parameter logic [XLEN-1:0] MCOUNTEREN_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: logic/csr_request_router.sv
`timescale 1ns/1ps
`default_nettype none
// Hart numbers at or above NUM_HARTS get no enable
// Only a CSR request to such a hart is reported, traps and mrets are dropped
module csr_request_router #(
  parameter int NUM_HARTS = 4
) (
  input  logic                 csr_valid,
  input  logic [2:0]           hart_sel,
  input  logic                 trap_valid,
  input  logic [2:0]           trap_hart,
  input  logic                 mret_valid,
  input  logic [2:0]           mret_hart,
  output logic [NUM_HARTS-1:0] hart_req,
  output logic [NUM_HARTS-1:0] hart_trap,
  output logic [NUM_HARTS-1:0] hart_mret,
  output logic                 bad_hart
);

  // One-hot decode limited to existing harts
  function automatic logic [NUM_HARTS-1:0] hart_enable(
    input logic       strobe,
    input logic [2:0] idx
  );
    logic [NUM_HARTS-1:0] en;
    en = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (strobe && (idx == 3'(h))) begin
        en[h] = 1'b1;
      end
    end
    return en;
  endfunction

  assign hart_req  = hart_enable(csr_valid, hart_sel);
  assign hart_trap = hart_enable(trap_valid, trap_hart);
  assign hart_mret = hart_enable(mret_valid, mret_hart);

  // Level only while the strobe is up
  assign bad_hart = csr_valid && (int'(hart_sel) >= NUM_HARTS);

endmodule

`default_nettype wire

// File: logic/hart_csr_file.sv
`timescale 1ns/1ps
`default_nettype none
// Machine CSRs of one RV32 hart; trap and mret win over a CSR write that same cycle
// Only MIE, MPIE, MPP, MPRV and TW exist in mstatus; mip bits 7 and 11 follow the pins
module hart_csr_file #(
  parameter int HARTID = 0
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          req,
  input  priv_csr_pkg::csr_op_t         csr_op,
  input  logic [11:0]                   csr_addr,
  input  logic [priv_csr_pkg::XLEN-1:0] csr_wdata,
  input  priv_csr_pkg::priv_level_t     curr_priv,
  input  logic                          trap,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_cause,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_pc,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_val,
  input  logic                          mret,
  input  logic                          inst_ret,
  input  logic                          irq_sw,
  input  logic                          irq_timer,
  input  logic                          irq_ext,
  output logic [priv_csr_pkg::XLEN-1:0] old_val,
  output logic                          csr_invalid,
  output logic                          irq_pending
);

  localparam int XLEN = priv_csr_pkg::XLEN;

  // mstatus fields
  logic                      mst_mie;
  logic                      mst_mpie;
  logic                      mst_mprv;
  logic                      mst_tw;
  priv_csr_pkg::priv_level_t mst_mpp;

  logic [XLEN-3:0]           mtvec_base;
  priv_csr_pkg::mtvec_mode_t mtvec_mode;

  logic [XLEN-1:0] mie;
  logic            mip_msip;  // Software-writable part of mip
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mtval;
  logic [XLEN-1:0] mcounteren;
  logic [XLEN-1:0] mcountinhibit;
  logic [63:0]     mcycle;
  logic [63:0]     minstret;

  logic [XLEN-1:0] mstatus_val;
  logic [XLEN-1:0] mip_val;
  logic [XLEN-1:0] new_val;
  logic            addr_known;
  logic            wr_en;

  always_comb begin
    mstatus_val = '0;
    mstatus_val[priv_csr_pkg::MSTATUS_MIE_BIT]  = mst_mie;
    mstatus_val[priv_csr_pkg::MSTATUS_MPIE_BIT] = mst_mpie;
    mstatus_val[priv_csr_pkg::MSTATUS_MPP_LSB +: 2] = mst_mpp;
    mstatus_val[priv_csr_pkg::MSTATUS_MPRV_BIT] = mst_mprv;
    mstatus_val[priv_csr_pkg::MSTATUS_TW_BIT]   = mst_tw;

    mip_val = '0;
    mip_val[priv_csr_pkg::IRQ_SW_BIT]    = mip_msip | irq_sw;
    mip_val[priv_csr_pkg::IRQ_TIMER_BIT] = irq_timer;
    mip_val[priv_csr_pkg::IRQ_EXT_BIT]   = irq_ext;
  end

  // Read mux, current value before any write
  always_comb begin
    old_val    = '0;
    addr_known = 1'b1;
    case (csr_addr)
      priv_csr_pkg::MVENDORID_ADDR,
      priv_csr_pkg::MARCHID_ADDR,
      priv_csr_pkg::MIMPID_ADDR,
      priv_csr_pkg::MCONFIGPTR_ADDR,
      priv_csr_pkg::MSTATUSH_ADDR:      old_val = '0;
      priv_csr_pkg::MHARTID_ADDR:       old_val = XLEN'(HARTID);
      priv_csr_pkg::MISA_ADDR:          old_val = priv_csr_pkg::MISA_VALUE;
      priv_csr_pkg::MSTATUS_ADDR:       old_val = mstatus_val;
      priv_csr_pkg::MTVEC_ADDR:         old_val = {mtvec_base, mtvec_mode};
      priv_csr_pkg::MIE_ADDR:           old_val = mie;
      priv_csr_pkg::MIP_ADDR:           old_val = mip_val;
      priv_csr_pkg::MSCRATCH_ADDR:      old_val = mscratch;
      priv_csr_pkg::MEPC_ADDR:          old_val = mepc;
      priv_csr_pkg::MCAUSE_ADDR:        old_val = mcause;
      priv_csr_pkg::MTVAL_ADDR:         old_val = mtval;
      priv_csr_pkg::MCOUNTEREN_ADDR:    old_val = mcounteren;
      priv_csr_pkg::MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      priv_csr_pkg::MCYCLE_ADDR:        old_val = mcycle[31:0];
      priv_csr_pkg::MCYCLEH_ADDR:       old_val = mcycle[63:32];
      priv_csr_pkg::MINSTRET_ADDR:      old_val = minstret[31:0];
      priv_csr_pkg::MINSTRETH_ADDR:     old_val = minstret[63:32];
      default:                          addr_known = 1'b0;
    endcase
  end

  // Privilege, existence and read-only checks
  assign csr_invalid = req && ((csr_addr[9:8] > curr_priv) || !addr_known ||
                               ((csr_op != priv_csr_pkg::CSR_READ) &&
                                (csr_addr[11:10] == 2'b11)));
  assign wr_en = req && !csr_invalid && (csr_op != priv_csr_pkg::CSR_READ);

  always_comb begin
    case (csr_op)
      priv_csr_pkg::CSR_RW: new_val = csr_wdata;
      priv_csr_pkg::CSR_RS: new_val = old_val | csr_wdata;
      priv_csr_pkg::CSR_RC: new_val = old_val & ~csr_wdata;
      default:              new_val = old_val;
    endcase
  end

  assign irq_pending = mst_mie && (|(mie & mip_val));

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mst_mie       <= 1'b0;
      mst_mpie      <= 1'b0;
      mst_mpp       <= priv_csr_pkg::M_MODE;
      mst_mprv      <= 1'b0;
      mst_tw        <= 1'b1;
      mtvec_base    <= '0;
      mtvec_mode    <= priv_csr_pkg::DIRECT;
      mie           <= '0;
      mip_msip      <= 1'b0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= priv_csr_pkg::MCOUNTEREN_RESET;
      mcountinhibit <= '0;
      mcycle        <= '0;
      minstret      <= '0;
    end else begin
      if (mcounteren[priv_csr_pkg::CNT_CY_BIT] && !mcountinhibit[priv_csr_pkg::CNT_CY_BIT]) begin
        mcycle <= mcycle + 64'd1;
      end
      if (mcounteren[priv_csr_pkg::CNT_IR_BIT] && !mcountinhibit[priv_csr_pkg::CNT_IR_BIT]) begin
        minstret <= minstret + 64'(inst_ret);
      end

      // A write to a counter half overrides the increment
      if (wr_en) begin
        case (csr_addr)
          priv_csr_pkg::MSTATUS_ADDR: begin
            mst_mie  <= new_val[priv_csr_pkg::MSTATUS_MIE_BIT];
            mst_mpie <= new_val[priv_csr_pkg::MSTATUS_MPIE_BIT];
            mst_mprv <= new_val[priv_csr_pkg::MSTATUS_MPRV_BIT];
            mst_tw   <= new_val[priv_csr_pkg::MSTATUS_TW_BIT];
            if (new_val[priv_csr_pkg::MSTATUS_MPP_LSB +: 2] == 2'b10) begin
              mst_mpp <= priv_csr_pkg::U_MODE;  // Reserved level
            end else begin
              mst_mpp <= priv_csr_pkg::priv_level_t'(new_val[priv_csr_pkg::MSTATUS_MPP_LSB +: 2]);
            end
          end
          priv_csr_pkg::MTVEC_ADDR: begin
            mtvec_base <= new_val[XLEN-1:2];
            if (new_val[1:0] > 2'b01) begin
              mtvec_mode <= priv_csr_pkg::DIRECT;
            end else begin
              mtvec_mode <= priv_csr_pkg::mtvec_mode_t'(new_val[1:0]);
            end
          end
          priv_csr_pkg::MIE_ADDR:           mie <= new_val & priv_csr_pkg::MIE_MASK;
          priv_csr_pkg::MIP_ADDR:           mip_msip <= new_val[priv_csr_pkg::IRQ_SW_BIT];
          priv_csr_pkg::MSCRATCH_ADDR:      mscratch <= new_val;
          priv_csr_pkg::MEPC_ADDR:          mepc <= new_val;
          priv_csr_pkg::MCAUSE_ADDR:        mcause <= new_val;
          priv_csr_pkg::MTVAL_ADDR:         mtval <= new_val;
          priv_csr_pkg::MCOUNTEREN_ADDR:    mcounteren <= new_val;
          priv_csr_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit <= new_val;
          priv_csr_pkg::MCYCLE_ADDR:        mcycle[31:0] <= new_val;
          priv_csr_pkg::MCYCLEH_ADDR:       mcycle[63:32] <= new_val;
          priv_csr_pkg::MINSTRET_ADDR:      minstret[31:0] <= new_val;
          priv_csr_pkg::MINSTRETH_ADDR:     minstret[63:32] <= new_val;
          default: ;  // Read-only or hardwired
        endcase
      end

      // Trap entry and return, last so they take priority
      if (trap) begin
        mst_mpie <= mst_mie;
        mst_mie  <= 1'b0;
        mst_mpp  <= priv_csr_pkg::M_MODE;
        mepc     <= trap_pc;
        mcause   <= trap_cause;
        mtval    <= trap_val;
      end else if (mret) begin
        mst_mie  <= mst_mpie;
        mst_mpie <= 1'b1;
      end
    end
  end

  // Trap and mret come from different pipeline events and must not overlap
  assert property (@(posedge CLK) disable iff (!nRST) !(trap && mret))
    else $error("hart %0d: trap and mret in the same cycle", HARTID);

endmodule

`default_nettype wire

// File: logic/csr_response_collector.sv
`timescale 1ns/1ps
`default_nettype none
// Every request gets a response one cycle later, there is no back-pressure
module csr_response_collector #(
  parameter int NUM_HARTS = 4
) (
  input  logic                                         CLK,
  input  logic                                         nRST,
  input  logic                                         csr_valid,
  input  logic [2:0]                                   hart_sel,
  input  logic                                         bad_hart,
  input  logic [NUM_HARTS-1:0][priv_csr_pkg::XLEN-1:0] old_vals,
  input  logic [NUM_HARTS-1:0]                         csr_invalids,
  output logic                                         rsp_valid,
  output logic [priv_csr_pkg::XLEN-1:0]                rsp_rdata,
  output logic                                         rsp_invalid
);

  logic [priv_csr_pkg::XLEN-1:0] sel_rdata;
  logic                          sel_invalid;

  // Missing hart answers zero data, flagged invalid
  always_comb begin
    sel_rdata   = '0;
    sel_invalid = bad_hart;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (!bad_hart && (hart_sel == 3'(h))) begin
        sel_rdata   = old_vals[h];
        sel_invalid = csr_invalids[h];
      end
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rsp_valid   <= 1'b0;
      rsp_invalid <= 1'b0;
    end else begin
      rsp_valid <= csr_valid;
      if (csr_valid) begin
        rsp_invalid <= sel_invalid;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (csr_valid) begin
      rsp_rdata <= sel_rdata;  // Value before the write
    end
  end

endmodule

`default_nettype wire

// File: logic/priv_csr_top.sv
`timescale 1ns/1ps
`default_nettype none
// NUM_HARTS from 1 to 8; a request at one edge answers in the following cycle
module priv_csr_top #(
  parameter int NUM_HARTS = 4
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          csr_valid,
  input  logic [2:0]                    hart_sel,
  input  priv_csr_pkg::csr_op_t         csr_op,
  input  logic [11:0]                   csr_addr,
  input  logic [priv_csr_pkg::XLEN-1:0] csr_wdata,
  input  priv_csr_pkg::priv_level_t     curr_priv,
  input  logic                          trap_valid,
  input  logic [2:0]                    trap_hart,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_cause,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_pc,
  input  logic [priv_csr_pkg::XLEN-1:0] trap_val,
  input  logic                          mret_valid,
  input  logic [2:0]                    mret_hart,
  input  logic [NUM_HARTS-1:0]          inst_ret,
  input  logic [NUM_HARTS-1:0]          irq_sw,
  input  logic [NUM_HARTS-1:0]          irq_timer,
  input  logic [NUM_HARTS-1:0]          irq_ext,
  output logic                          rsp_valid,
  output logic [priv_csr_pkg::XLEN-1:0] rsp_rdata,
  output logic                          rsp_invalid,
  output logic [NUM_HARTS-1:0]          irq_pending
);

  logic [NUM_HARTS-1:0]                         hart_req;
  logic [NUM_HARTS-1:0]                         hart_trap;
  logic [NUM_HARTS-1:0]                         hart_mret;
  logic                                         bad_hart;
  logic [NUM_HARTS-1:0][priv_csr_pkg::XLEN-1:0] old_vals;
  logic [NUM_HARTS-1:0]                         csr_invalids;

  csr_request_router #(.NUM_HARTS(NUM_HARTS)) u_router (
    .csr_valid (csr_valid),
    .hart_sel  (hart_sel),
    .trap_valid(trap_valid),
    .trap_hart (trap_hart),
    .mret_valid(mret_valid),
    .mret_hart (mret_hart),
    .hart_req  (hart_req),
    .hart_trap (hart_trap),
    .hart_mret (hart_mret),
    .bad_hart  (bad_hart)
  );

  // Address, data and trap fields go to all harts, enables pick one
  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    hart_csr_file #(.HARTID(h)) u_hart (
      .CLK        (CLK),
      .nRST       (nRST),
      .req        (hart_req[h]),
      .csr_op     (csr_op),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .curr_priv  (curr_priv),
      .trap       (hart_trap[h]),
      .trap_cause (trap_cause),
      .trap_pc    (trap_pc),
      .trap_val   (trap_val),
      .mret       (hart_mret[h]),
      .inst_ret   (inst_ret[h]),
      .irq_sw     (irq_sw[h]),
      .irq_timer  (irq_timer[h]),
      .irq_ext    (irq_ext[h]),
      .old_val    (old_vals[h]),
      .csr_invalid(csr_invalids[h]),
      .irq_pending(irq_pending[h])
    );
  end

  csr_response_collector #(.NUM_HARTS(NUM_HARTS)) u_collector (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_valid   (csr_valid),
    .hart_sel    (hart_sel),
    .bad_hart    (bad_hart),
    .old_vals    (old_vals),
    .csr_invalids(csr_invalids),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .rsp_invalid (rsp_invalid)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none
// Free-running clock with a low reset held for a fixed number of cycles
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/priv_csr_tb.sv
`timescale 1ns/1ps
`default_nettype none
// Four harts; inputs change on the falling edge and responses are checked one edge later
// Random mscratch data uses a fixed xorshift seed, other expected values are constants
module priv_csr_tb;

  localparam int NUM_HARTS = 4;
  localparam logic [1:0] K_REQ  = 2'd0;
  localparam logic [1:0] K_TRAP = 2'd1;
  localparam logic [1:0] K_MRET = 2'd2;
  localparam logic [1:0] K_IDLE = 2'd3;
  localparam logic [2:0] M_EXACT   = 3'd0;
  localparam logic [2:0] M_NODATA  = 3'd1;
  localparam logic [2:0] M_RANDOM  = 3'd2;  // mscratch shadow model
  localparam logic [2:0] M_RECORD  = 3'd3;
  localparam logic [2:0] M_GREATER = 3'd4;
  localparam logic [2:0] M_EQUAL   = 3'd5;
  localparam logic [31:0] TRAP_CAUSE    = 32'h8000_0007;
  localparam logic [31:0] TRAP_VAL      = 32'h0000_1234;
  localparam logic [31:0] RESET_MSTATUS = 32'h0020_1800;  // TW=1, MPP=M

  typedef struct packed {
    logic [1:0]                kind;
    logic [2:0]                mode;
    priv_csr_pkg::csr_op_t     op;
    logic [2:0]                hart;
    logic [11:0]               addr;
    logic [31:0]               data;
    priv_csr_pkg::priv_level_t priv;
    logic [31:0]               exp;
    logic                      exp_inv;
    logic [NUM_HARTS-1:0]      timer;
    logic [NUM_HARTS-1:0]      exp_irq;
    logic [NUM_HARTS-1:0]      ret;
  } entry_t;

  logic CLK;
  logic nRST;
  logic csr_valid;
  logic [2:0] hart_sel;
  priv_csr_pkg::csr_op_t csr_op;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  priv_csr_pkg::priv_level_t curr_priv;
  logic trap_valid;
  logic [2:0] trap_hart;
  logic [31:0] trap_cause;
  logic [31:0] trap_pc;
  logic [31:0] trap_val;
  logic mret_valid;
  logic [2:0] mret_hart;
  logic [NUM_HARTS-1:0] inst_ret;
  logic [NUM_HARTS-1:0] irq_sw;
  logic [NUM_HARTS-1:0] irq_timer;
  logic [NUM_HARTS-1:0] irq_ext;
  logic rsp_valid;
  logic [31:0] rsp_rdata;
  logic rsp_invalid;
  logic [NUM_HARTS-1:0] irq_pending;

  entry_t table_q[$];
  entry_t cur;
  logic [31:0] shadow [0:7];
  logic [31:0] rng_state = 32'h3370_4152;
  logic [31:0] last_count;
  logic [NUM_HARTS-1:0] timer_lvl;  // Pin levels and expected irq while building
  logic [NUM_HARTS-1:0] irq_exp;
  int err_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int timeout_limit = 1000000;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (.CLK(CLK), .nRST(nRST));

  priv_csr_top #(.NUM_HARTS(NUM_HARTS)) uut (
    .CLK(CLK), .nRST(nRST), .csr_valid(csr_valid), .hart_sel(hart_sel),
    .csr_op(csr_op), .csr_addr(csr_addr), .csr_wdata(csr_wdata), .curr_priv(curr_priv),
    .trap_valid(trap_valid), .trap_hart(trap_hart), .trap_cause(trap_cause),
    .trap_pc(trap_pc), .trap_val(trap_val), .mret_valid(mret_valid), .mret_hart(mret_hart),
    .inst_ret(inst_ret), .irq_sw(irq_sw), .irq_timer(irq_timer), .irq_ext(irq_ext),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_invalid(rsp_invalid),
    .irq_pending(irq_pending)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // RW, RS and RC rules for the shadow model
  function automatic logic [31:0] apply_op(input priv_csr_pkg::csr_op_t op,
                                           input logic [31:0] old, input logic [31:0] d);
    case (op)
      priv_csr_pkg::CSR_RW: return d;
      priv_csr_pkg::CSR_RS: return old | d;
      priv_csr_pkg::CSR_RC: return old & ~d;
      default:              return old;
    endcase
  endfunction

  task automatic add_req(input priv_csr_pkg::csr_op_t op, input logic [2:0] hart,
                         input logic [11:0] addr, input logic [31:0] data,
                         input priv_csr_pkg::priv_level_t priv, input logic [31:0] exp,
                         input logic exp_inv, input logic [2:0] mode);
    entry_t e;
    e = '0;
    e.kind = K_REQ;
    e.mode = mode;
    e.op = op;
    e.hart = hart;
    e.addr = addr;
    e.data = data;
    e.priv = priv;
    e.exp = exp;
    e.exp_inv = exp_inv;
    e.timer = timer_lvl;
    e.exp_irq = irq_exp;
    table_q.push_back(e);
  endtask

  // Trap, mret or idle cycle with optional retire pulses
  task automatic add_event(input logic [1:0] kind, input logic [2:0] hart,
                           input logic [31:0] data, input logic [NUM_HARTS-1:0] ret);
    entry_t e;
    e = '0;
    e.kind = kind;
    e.op = priv_csr_pkg::CSR_READ;
    e.hart = hart;
    e.data = data;
    e.priv = priv_csr_pkg::M_MODE;
    e.timer = timer_lvl;
    e.exp_irq = irq_exp;
    e.ret = ret;
    table_q.push_back(e);
  endtask

  task automatic add_read(input logic [2:0] hart, input logic [11:0] addr,
                          input logic [31:0] exp);
    add_req(priv_csr_pkg::CSR_READ, hart, addr, '0, priv_csr_pkg::M_MODE, exp, 1'b0, M_EXACT);
  endtask

  task automatic add_write(input priv_csr_pkg::csr_op_t op, input logic [2:0] hart,
                           input logic [11:0] addr, input logic [31:0] data,
                           input logic [31:0] exp_old);
    add_req(op, hart, addr, data, priv_csr_pkg::M_MODE, exp_old, 1'b0, M_EXACT);
  endtask

  task automatic add_scratch(input priv_csr_pkg::csr_op_t op, input logic [2:0] hart,
                             input priv_csr_pkg::priv_level_t priv, input logic inv);
    add_req(op, hart, priv_csr_pkg::MSCRATCH_ADDR, '0, priv, '0, inv, M_RANDOM);
  endtask

  task automatic build_table();
    timer_lvl = '0;
    irq_exp = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      add_read(3'(h), priv_csr_pkg::MHARTID_ADDR, 32'(h));
      add_read(3'(h), priv_csr_pkg::MISA_ADDR, 32'h4000_0100);  // RV32, I only
      add_scratch(priv_csr_pkg::CSR_RW, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
      add_scratch(priv_csr_pkg::CSR_READ, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
      add_scratch(priv_csr_pkg::CSR_RS, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
      add_scratch(priv_csr_pkg::CSR_READ, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
      add_scratch(priv_csr_pkg::CSR_RC, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
      add_scratch(priv_csr_pkg::CSR_READ, 3'(h), priv_csr_pkg::M_MODE, 1'b0);
    end
    // Legal values on hart 0
    add_write(priv_csr_pkg::CSR_RW, 3'd0, priv_csr_pkg::MSTATUS_ADDR, 32'h1000, RESET_MSTATUS);
    add_read(3'd0, priv_csr_pkg::MSTATUS_ADDR, 32'h0);
    add_write(priv_csr_pkg::CSR_RW, 3'd0, priv_csr_pkg::MTVEC_ADDR, 32'h1003, 32'h0);
    add_read(3'd0, priv_csr_pkg::MTVEC_ADDR, 32'h1000);
    add_write(priv_csr_pkg::CSR_RW, 3'd0, priv_csr_pkg::MIE_ADDR, 32'hFFFF_FFFF, 32'h0);
    add_read(3'd0, priv_csr_pkg::MIE_ADDR, 32'h888);
    // Invalid accesses, hart 2 and missing harts
    add_req(priv_csr_pkg::CSR_READ, 3'd2, 12'h7C0, '0, priv_csr_pkg::M_MODE, '0, 1'b1, M_NODATA);
    add_req(priv_csr_pkg::CSR_RW, 3'd2, priv_csr_pkg::MHARTID_ADDR, 32'h5,
            priv_csr_pkg::M_MODE, '0, 1'b1, M_NODATA);
    add_read(3'd2, priv_csr_pkg::MHARTID_ADDR, 32'h2);
    add_scratch(priv_csr_pkg::CSR_RW, 3'd2, priv_csr_pkg::U_MODE, 1'b1);
    add_scratch(priv_csr_pkg::CSR_READ, 3'd2, priv_csr_pkg::M_MODE, 1'b0);
    add_req(priv_csr_pkg::CSR_READ, 3'(NUM_HARTS), priv_csr_pkg::MSCRATCH_ADDR, '0,
            priv_csr_pkg::M_MODE, 32'h0, 1'b1, M_EXACT);
    add_req(priv_csr_pkg::CSR_RW, 3'd7, priv_csr_pkg::MSCRATCH_ADDR, 32'hFFFF_FFFF,
            priv_csr_pkg::M_MODE, 32'h0, 1'b1, M_EXACT);
    add_scratch(priv_csr_pkg::CSR_READ, 3'd3, priv_csr_pkg::M_MODE, 1'b0);
    // Trap and mret on hart 1, hart 2 must not move
    add_write(priv_csr_pkg::CSR_RW, 3'd1, priv_csr_pkg::MSTATUS_ADDR, 32'h1808, RESET_MSTATUS);
    add_read(3'd1, priv_csr_pkg::MSTATUS_ADDR, 32'h1808);
    add_event(K_TRAP, 3'd1, 32'h8000_0100, '0);
    add_read(3'd1, priv_csr_pkg::MEPC_ADDR, 32'h8000_0100);
    add_read(3'd1, priv_csr_pkg::MCAUSE_ADDR, TRAP_CAUSE);
    add_read(3'd1, priv_csr_pkg::MTVAL_ADDR, TRAP_VAL);
    add_read(3'd1, priv_csr_pkg::MSTATUS_ADDR, 32'h1880);  // MPIE set, MIE clear
    add_read(3'd2, priv_csr_pkg::MEPC_ADDR, 32'h0);
    add_read(3'd2, priv_csr_pkg::MSTATUS_ADDR, RESET_MSTATUS);
    add_event(K_MRET, 3'd1, '0, '0);
    add_read(3'd1, priv_csr_pkg::MSTATUS_ADDR, 32'h1888);
    // Timer interrupt on hart 3; hart 0 has MTIE but MIE clear
    add_write(priv_csr_pkg::CSR_RW, 3'd3, priv_csr_pkg::MIE_ADDR, 32'h80, 32'h0);
    timer_lvl = 4'b1001;
    add_read(3'd3, priv_csr_pkg::MIP_ADDR, 32'h80);
    add_read(3'd0, priv_csr_pkg::MIP_ADDR, 32'h80);
    irq_exp = 4'b1000;
    add_write(priv_csr_pkg::CSR_RS, 3'd3, priv_csr_pkg::MSTATUS_ADDR, 32'h8, RESET_MSTATUS);
    add_read(3'd3, priv_csr_pkg::MSTATUS_ADDR, RESET_MSTATUS | 32'h8);
    timer_lvl = '0;
    irq_exp = '0;
    add_read(3'd3, priv_csr_pkg::MIP_ADDR, 32'h0);
    // Counters on hart 0
    add_req(priv_csr_pkg::CSR_READ, 3'd0, priv_csr_pkg::MCYCLE_ADDR, '0,
            priv_csr_pkg::M_MODE, '0, 1'b0, M_RECORD);
    add_req(priv_csr_pkg::CSR_READ, 3'd0, priv_csr_pkg::MCYCLE_ADDR, '0,
            priv_csr_pkg::M_MODE, '0, 1'b0, M_GREATER);
    add_write(priv_csr_pkg::CSR_RS, 3'd0, priv_csr_pkg::MCOUNTINHIBIT_ADDR, 32'h1, 32'h0);
    add_req(priv_csr_pkg::CSR_READ, 3'd0, priv_csr_pkg::MCYCLE_ADDR, '0,
            priv_csr_pkg::M_MODE, '0, 1'b0, M_RECORD);
    add_req(priv_csr_pkg::CSR_READ, 3'd0, priv_csr_pkg::MCYCLE_ADDR, '0,
            priv_csr_pkg::M_MODE, '0, 1'b0, M_EQUAL);
    add_write(priv_csr_pkg::CSR_RW, 3'd0, priv_csr_pkg::MINSTRET_ADDR, 32'h0, 32'h0);
    repeat (3) add_event(K_IDLE, 3'd0, '0, NUM_HARTS'(1));
    add_read(3'd0, priv_csr_pkg::MINSTRET_ADDR, 32'h3);
    add_write(priv_csr_pkg::CSR_RS, 3'd0, priv_csr_pkg::MCOUNTINHIBIT_ADDR, 32'h4, 32'h1);
    repeat (2) add_event(K_IDLE, 3'd0, '0, NUM_HARTS'(1));
    add_read(3'd0, priv_csr_pkg::MINSTRET_ADDR, 32'h3);  // Inhibited, no change
  endtask

  // Applies one entry and resolves random data and shadow expectations
  task automatic drive_entry(input entry_t e, output entry_t r);
    csr_valid = 1'b0;
    trap_valid = 1'b0;
    mret_valid = 1'b0;
    inst_ret = '0;
    irq_timer = e.timer;
    hart_sel = e.hart;
    csr_op = e.op;
    csr_addr = e.addr;
    curr_priv = e.priv;
    if (e.mode == M_RANDOM) begin
      if (e.op != priv_csr_pkg::CSR_READ) begin
        rng_state = xorshift32(rng_state);
        e.data = rng_state;
      end
      e.exp = shadow[e.hart];
      if (!e.exp_inv) begin
        shadow[e.hart] = apply_op(e.op, shadow[e.hart], e.data);
      end
    end
    csr_wdata = e.data;
    case (e.kind)
      K_REQ: csr_valid = 1'b1;
      K_TRAP: begin
        trap_valid = 1'b1;
        trap_hart = e.hart;
        trap_pc = e.data;
        trap_cause = TRAP_CAUSE;
        trap_val = TRAP_VAL;
      end
      K_MRET: begin
        mret_valid = 1'b1;
        mret_hart = e.hart;
      end
      default: inst_ret = e.ret;
    endcase
    r = e;
  endtask

  task automatic report_mismatch(input string name, input int idx,
                                 input logic [31:0] exp, input logic [31:0] got);
    $display("Error: %s entry %0d expected %h got %h", name, idx, exp, got);
    err_count++;
  endtask

  task automatic check_entry(input entry_t e, input int idx);
    check_count++;
    if (e.kind == K_REQ) begin
      if (rsp_valid !== 1'b1) report_mismatch("rsp_valid", idx, 32'h1, 32'(rsp_valid));
      if (rsp_invalid !== e.exp_inv) begin
        report_mismatch("rsp_invalid", idx, 32'(e.exp_inv), 32'(rsp_invalid));
      end
      if (e.mode == M_RECORD) begin
        last_count = rsp_rdata;
      end else if (e.mode == M_GREATER) begin
        if (!(rsp_rdata > last_count)) begin
          $display("Error: rsp_rdata entry %0d expected above %h got %h",
                   idx, last_count, rsp_rdata);
          err_count++;
        end
        last_count = rsp_rdata;
      end else if (e.mode == M_EQUAL) begin
        if (rsp_rdata !== last_count) report_mismatch("rsp_rdata", idx, last_count, rsp_rdata);
      end else if (e.mode != M_NODATA) begin
        if (rsp_rdata !== e.exp) report_mismatch("rsp_rdata", idx, e.exp, rsp_rdata);
      end
    end else if (rsp_valid !== 1'b0) begin
      report_mismatch("rsp_valid", idx, 32'h0, 32'(rsp_valid));
    end
    if (irq_pending !== e.exp_irq) begin
      report_mismatch("irq_pending", idx, 32'(e.exp_irq), 32'(irq_pending));
    end
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    csr_valid = 1'b0;
    hart_sel = '0;
    csr_op = priv_csr_pkg::CSR_READ;
    csr_addr = '0;
    csr_wdata = '0;
    curr_priv = priv_csr_pkg::M_MODE;
    trap_valid = 1'b0;
    trap_hart = '0;
    trap_cause = '0;
    trap_pc = '0;
    trap_val = '0;
    mret_valid = 1'b0;
    mret_hart = '0;
    inst_ret = '0;
    irq_sw = '0;
    irq_timer = '0;
    irq_ext = '0;
    last_count = '0;
    for (int i = 0; i < 8; i++) shadow[i] = '0;  // mscratch resets to zero
    build_table();
    timeout_limit = table_q.size() * 4 + 100;

    wait (nRST === 1'b1);
    @(negedge CLK);
    check_count++;
    if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", -1, 32'h0, 32'(rsp_valid));
    if (irq_pending !== '0) report_mismatch("irq_pending", -1, 32'h0, 32'(irq_pending));

    for (int i = 0; i < table_q.size(); i++) begin
      drive_entry(table_q[i], cur);
      @(negedge CLK);
      check_entry(cur, i);
    end
    csr_valid = 1'b0;
    trap_valid = 1'b0;
    mret_valid = 1'b0;
    inst_ret = '0;
    @(negedge CLK);

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
logic/priv_csr_pkg.sv
logic/csr_request_router.sv
logic/hart_csr_file.sv
logic/csr_response_collector.sv
logic/priv_csr_top.sv
dv/tb_clock_gen.sv
dv/priv_csr_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = priv_csr_tb
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: sim clean

# Pass only when the testbench prints its pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD)
